// ==== os_gen_pkg.sv ====
`default_nettype none

package os_gen_pkg;

   localparam int NUM_LANES    = 4;
   localparam int SYMS_PER_CLK = 2;                        // 1, 2 or 4 symbols per lane
   localparam int BEAT_SYMS    = NUM_LANES * SYMS_PER_CLK; // symbol slots per beat

   localparam int TS_LEN    = 16; // TS1 / TS2 length in symbols
   localparam int SHORT_LEN = 4;  // SKP / EIOS length in symbols

   // 8b/10b symbol codes
   localparam logic [7:0] SYM_COM       = 8'hbc; // K28.5
   localparam logic [7:0] SYM_PAD       = 8'hf7; // K23.7
   localparam logic [7:0] SYM_SKP       = 8'h1c; // K28.0
   localparam logic [7:0] SYM_EIDL      = 8'h7c; // K28.3
   localparam logic [7:0] TS1_ID        = 8'h4a; // D10.2
   localparam logic [7:0] TS2_ID        = 8'h45; // D5.2
   localparam logic [7:0] TCTL_LOOPBACK = 8'h04; // training control bit 2

   typedef enum logic [1:0] {
      TS1  = 2'd0,
      TS2  = 2'd1,
      SKP  = 2'd2,
      EIOS = 2'd3
   } os_type_e;

   typedef enum logic [1:0] {
      LANE_PAD = 2'd0,
      LANE_SEQ = 2'd1,
      LANE_REV = 2'd2 // code 3 also reverses
   } lane_mode_e;

   // request as presented with start
   typedef struct packed {
      os_type_e   os_type;
      logic [7:0] link_number;
      logic [2:0] rate;
      logic       loopback;
      lane_mode_e lane_mode;
   } os_request_t;

   // decoded TS content, held for the length of the set
   typedef struct packed {
      os_type_e                  os_type;
      logic [7:0]                link_sym;
      logic                      link_k;    // set when link_sym is PAD
      logic [7:0]                rate_id;
      logic [7:0]                train_ctl;
      logic [7:0]                ident;     // symbols 6..15
      logic [NUM_LANES-1:0][7:0] lane_sym;
      logic                      lane_k;    // set when lane_sym is PAD
   } ts_fields_t;

   typedef struct packed {
      logic       active;
      logic [3:0] base;   // symbol index carried by slot 0
      logic       last;
   } beat_pos_t;

   // slot j of lane i sits at j*NUM_LANES+i
   typedef struct packed {
      logic [BEAT_SYMS*8-1:0] data;
      logic [BEAT_SYMS-1:0]   datak;
      logic [BEAT_SYMS-1:0]   data_valid;
   } os_beat_t;

endpackage

`default_nettype wire

// ==== os_field_builder.sv ====
`timescale 1ns/10ps
`default_nettype none

module os_field_builder (
   input  wire logic                    pclk,
   input  wire logic                    reset_n,
   input  wire logic                    start,
   input  wire os_gen_pkg::os_request_t req,
   output os_gen_pkg::ts_fields_t       fields
);

   os_gen_pkg::ts_fields_t next_fields;

   always_comb begin
      next_fields.os_type = req.os_type;

      // link number 0 means no link assigned yet
      next_fields.link_k   = (req.link_number == 8'h00);
      next_fields.link_sym = next_fields.link_k ? os_gen_pkg::SYM_PAD : req.link_number;

      case (req.rate)
         3'd1:    next_fields.rate_id = 8'h02;
         3'd2:    next_fields.rate_id = 8'h04;
         3'd3:    next_fields.rate_id = 8'h08;
         3'd4:    next_fields.rate_id = 8'h10;
         default: next_fields.rate_id = 8'h20;
      endcase

      next_fields.train_ctl = req.loopback ? os_gen_pkg::TCTL_LOOPBACK : 8'h00;
      next_fields.ident     = (req.os_type == os_gen_pkg::TS2) ? os_gen_pkg::TS2_ID
                                                               : os_gen_pkg::TS1_ID;

      // one lane number per lane, same rule for TS1 and TS2
      next_fields.lane_k = (req.lane_mode == os_gen_pkg::LANE_PAD);
      for (int i = 0; i < os_gen_pkg::NUM_LANES; i++) begin
         case (req.lane_mode)
            os_gen_pkg::LANE_PAD: next_fields.lane_sym[i] = os_gen_pkg::SYM_PAD;
            os_gen_pkg::LANE_SEQ: next_fields.lane_sym[i] = 8'(i);
            default:              next_fields.lane_sym[i] = 8'(os_gen_pkg::NUM_LANES - 1 - i);
         endcase
      end
   end

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         fields <= '0;
      end else if (start) begin
         fields <= next_fields; // held until the next request
      end
   end

endmodule

`default_nettype wire

// ==== os_symbol_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module os_symbol_sequencer (
   input  wire logic                 pclk,
   input  wire logic                 reset_n,
   input  wire logic                 start,
   input  wire os_gen_pkg::os_type_e os_type,
   output os_gen_pkg::beat_pos_t     pos,
   output logic                      busy
);

   logic [4:0] set_len;   // symbols in the set being sent
   logic [4:0] start_len;
   logic [5:0] next_base;
   logic [5:0] next_end;  // one past the final symbol of the next beat

   assign start_len = (os_type == os_gen_pkg::TS1 || os_type == os_gen_pkg::TS2) ?
                      5'(os_gen_pkg::TS_LEN) : 5'(os_gen_pkg::SHORT_LEN);
   assign next_base = {2'b00, pos.base} + 6'(os_gen_pkg::SYMS_PER_CLK);
   assign next_end  = next_base + 6'(os_gen_pkg::SYMS_PER_CLK);

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         pos     <= '0;
         set_len <= '0;
      end else if (start) begin
         pos.active <= 1'b1;
         pos.base   <= '0;
         pos.last   <= (os_gen_pkg::SYMS_PER_CLK >= int'(start_len)); // one-beat set
         set_len    <= start_len;
      end else if (pos.last) begin
         pos <= '0; // set done, back to idle
      end else if (pos.active) begin
         pos.base <= next_base[3:0];
         pos.last <= (next_end >= {1'b0, set_len});
      end
   end

   // low on the last position so a new start lines up back to back
   assign busy = pos.active & ~pos.last;

   a_no_start_busy: assert property (@(posedge pclk) disable iff (!reset_n)
      start |-> !busy)
      else $error("start while busy");

   // last only repeats when a new one-beat set starts on top of it
   a_last_single: assert property (@(posedge pclk) disable iff (!reset_n)
      pos.last && !start |=> !pos.last)
      else $error("last held for more than one cycle");

   // busy drops only once the counter has reached the final beat of the set
   a_busy_fall: assert property (@(posedge pclk) disable iff (!reset_n)
      $fell(busy) |-> (next_base >= {1'b0, set_len}))
      else $error("busy dropped before the last beat");

endmodule

`default_nettype wire

// ==== os_lane_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module os_lane_packer (
   input  wire logic                   pclk,
   input  wire logic                   reset_n,
   input  wire os_gen_pkg::ts_fields_t fields,
   input  wire os_gen_pkg::beat_pos_t  pos,
   output os_gen_pkg::os_beat_t        beat,
   output logic                        finish
);

   os_gen_pkg::os_beat_t next_beat;

   // returns {k, symbol} for symbol idx of the set on one lane
   function automatic logic [8:0] pick_symbol(
      input os_gen_pkg::ts_fields_t f,
      input logic [3:0]             idx,
      input int                     lane
   );
      logic [8:0] sym_k;
      case (f.os_type)
         os_gen_pkg::SKP: begin
            sym_k = (idx == 4'd0) ? {1'b1, os_gen_pkg::SYM_COM} : {1'b1, os_gen_pkg::SYM_SKP};
         end
         os_gen_pkg::EIOS: begin
            sym_k = (idx == 4'd0) ? {1'b1, os_gen_pkg::SYM_COM} : {1'b1, os_gen_pkg::SYM_EIDL};
         end
         default: begin
            case (idx)
               4'd0:    sym_k = {1'b1, os_gen_pkg::SYM_COM};
               4'd1:    sym_k = {f.link_k, f.link_sym};
               4'd2:    sym_k = {f.lane_k, f.lane_sym[lane]}; // only per-lane symbol
               4'd3:    sym_k = {1'b0, 8'h00};                // n_fts not used here
               4'd4:    sym_k = {1'b0, f.rate_id};
               4'd5:    sym_k = {1'b0, f.train_ctl};
               default: sym_k = {1'b0, f.ident};
            endcase
         end
      endcase
      return sym_k;
   endfunction

   always_comb begin
      logic [8:0] sym_k;
      next_beat = '0;
      for (int j = 0; j < os_gen_pkg::SYMS_PER_CLK; j++) begin
         for (int i = 0; i < os_gen_pkg::NUM_LANES; i++) begin
            sym_k = pick_symbol(fields, pos.base + 4'(j), i);
            next_beat.data[(j*os_gen_pkg::NUM_LANES+i)*8 +: 8] = sym_k[7:0];
            next_beat.datak[j*os_gen_pkg::NUM_LANES+i]         = sym_k[8];
         end
      end
      next_beat.data_valid = '1; // every slot carries a symbol
   end

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         beat   <= '0;
         finish <= 1'b0;
      end else if (pos.active) begin
         beat   <= next_beat;
         finish <= pos.last;
      end else begin
         beat   <= '0; // idle, no valid symbols
         finish <= 1'b0;
      end
   end

   // the whole beat is valid or idle, and finish never comes with an idle beat
   a_valid_whole: assert property (@(posedge pclk) disable iff (!reset_n)
      (&beat.data_valid) || (beat.data_valid == '0 && !finish))
      else $error("partial data_valid or finish on idle beat");

endmodule

`default_nettype wire

// ==== os_generator.sv ====
`timescale 1ns/10ps
`default_nettype none

module os_generator (
   input  wire logic                    pclk,
   input  wire logic                    reset_n,
   input  wire logic                    start,
   input  wire os_gen_pkg::os_request_t req,
   output wire os_gen_pkg::os_beat_t    beat,
   output wire logic                    busy,
   output wire logic                    finish
);

   wire os_gen_pkg::ts_fields_t fields; // captured TS content
   wire os_gen_pkg::beat_pos_t  pos;    // position one cycle ahead of the beat

   os_field_builder u_field_builder (
      .pclk    (pclk),
      .reset_n (reset_n),
      .start   (start),
      .req     (req),
      .fields  (fields)
   );

   os_symbol_sequencer u_symbol_sequencer (
      .pclk    (pclk),
      .reset_n (reset_n),
      .start   (start),
      .os_type (req.os_type),
      .pos     (pos),
      .busy    (busy)
   );

   os_lane_packer u_lane_packer (
      .pclk    (pclk),
      .reset_n (reset_n),
      .fields  (fields),
      .pos     (pos),
      .beat    (beat),
      .finish  (finish)
   );

endmodule

`default_nettype wire

// ==== tb_os_generator.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_os_generator;

   logic                    pclk;
   logic                    reset_n;
   logic                    start;
   os_gen_pkg::os_request_t req;
   os_gen_pkg::os_beat_t    beat;
   logic                    busy;
   logic                    finish;

   os_gen_pkg::os_request_t req_q[$];  // requests in file order
   int                      gap_q[$];
   int                      len_q[$];  // beats per request
   os_gen_pkg::os_beat_t    exp_q[$];  // expected beats, all requests

   integer seed;
   bit     loaded;
   int     limit_cycles;
   int     remaining;   // beats still due from the running set
   int     next_len;    // set length of a start seen at the last edge
   int     checks;
   int     beat_errors;
   int     flag_errors;
   int     other_errors;

   os_generator UUT (
      .pclk    (pclk),
      .reset_n (reset_n),
      .start   (start),
      .req     (req),
      .beat    (beat),
      .busy    (busy),
      .finish  (finish)
   );

   initial begin
      pclk = 1'b0;
      forever #4 pclk = ~pclk;
   end

   task automatic check_beat(input os_gen_pkg::os_beat_t got, input os_gen_pkg::os_beat_t exp);
      checks++;
      if (got.data !== exp.data) begin
         beat_errors++;
         $display("mismatch beat.data: got %h, expected %h at %0t", got.data, exp.data, $time);
      end
      if (got.datak !== exp.datak) begin
         beat_errors++;
         $display("mismatch beat.datak: got %h, expected %h at %0t", got.datak, exp.datak, $time);
      end
      if (got.data_valid !== exp.data_valid) begin
         beat_errors++;
         $display("mismatch beat.data_valid: got %h, expected %h at %0t",
                  got.data_valid, exp.data_valid, $time);
      end
   endtask

   task automatic check_flags(input logic got_busy, input logic got_finish,
                              input logic exp_busy, input logic exp_finish);
      checks++;
      if (got_busy !== exp_busy) begin
         flag_errors++;
         $display("mismatch busy: got %h, expected %h at %0t", got_busy, exp_busy, $time);
      end
      if (got_finish !== exp_finish) begin
         flag_errors++;
         $display("mismatch finish: got %h, expected %h at %0t", got_finish, exp_finish, $time);
      end
   endtask

   task automatic print_counts();
      $display("checks %0d, beat errors %0d, flag errors %0d, other errors %0d",
               checks, beat_errors, flag_errors, other_errors);
   endtask

   // R lines open a request, the E lines after it are its beats
   task automatic load_vectors(output bit ok);
      int                                  fd;
      int                                  c;
      int                                  n;
      int                                  total_gaps;
      logic [7:0]                          ch;
      logic [31:0]                         f_type;
      logic [31:0]                         f_link;
      logic [31:0]                         f_rate;
      logic [31:0]                         f_loop;
      logic [31:0]                         f_mode;
      logic [31:0]                         f_gap;
      logic [os_gen_pkg::BEAT_SYMS*8-1:0]  f_data;
      logic [os_gen_pkg::BEAT_SYMS-1:0]    f_datak;
      logic [8*128-1:0]                    skip;
      os_gen_pkg::os_request_t             r;
      os_gen_pkg::os_beat_t                b;
      ok         = 1'b0;
      total_gaps = 0;
      fd = $fopen("os_vectors.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("error: cannot open os_vectors.txt");
         return;
      end
      c = $fgetc(fd);
      while (c != -1) begin
         ch = c[7:0];
         if (ch == "#") begin
            n = $fgets(skip, fd); // comment line
         end else if (ch == "R") begin
            n = $fscanf(fd, "%h %h %h %h %h %h", f_type, f_link, f_rate, f_loop, f_mode, f_gap);
            if (n != 6) begin
               other_errors++;
               $display("error: request line %0d is incomplete", req_q.size() + 1);
            end
            r.os_type     = os_gen_pkg::os_type_e'(f_type[1:0]);
            r.link_number = f_link[7:0];
            r.rate        = f_rate[2:0];
            r.loopback    = f_loop[0];
            r.lane_mode   = os_gen_pkg::lane_mode_e'(f_mode[1:0]);
            req_q.push_back(r);
            gap_q.push_back(int'(f_gap));
            len_q.push_back(0);
            total_gaps += (f_gap == 0) ? 4 : int'(f_gap);
         end else if (ch == "E") begin
            n = $fscanf(fd, "%h %h", f_data, f_datak);
            if (n != 2 || len_q.size() == 0) begin
               other_errors++;
               $display("error: beat line without a request or with missing fields");
            end else begin
               b.data       = f_data;
               b.datak      = f_datak;
               b.data_valid = '1;
               exp_q.push_back(b);
               len_q[len_q.size() - 1] += 1;
            end
         end else if (ch != 8'd32 && ch != 8'd10 && ch != 8'd13 && ch != 8'd9) begin
            other_errors++;
            $display("error: unexpected character in vector file");
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
      if (req_q.size() == 0) begin
         other_errors++;
         $display("error: no request found in os_vectors.txt");
      end
      limit_cycles = exp_q.size() + total_gaps + 64;
      ok = (other_errors == 0) && (req_q.size() > 0);
   endtask

   initial begin : driver
      bit                      ok;
      int                      gap;
      int                      n;
      os_gen_pkg::os_request_t r;
      seed         = 32'h434e;
      start        = 1'b0;
      req          = '0;
      reset_n      = 1'b0;
      remaining    = 0;
      next_len     = 0;
      checks       = 0;
      beat_errors  = 0;
      flag_errors  = 0;
      other_errors = 0;
      limit_cycles = 64;
      load_vectors(ok);
      loaded = 1'b1;
      repeat (16) @(negedge pclk);
      reset_n = 1'b1;
      if (ok) begin
         while (req_q.size() > 0) begin
            r   = req_q.pop_front();
            gap = gap_q.pop_front();
            if (gap == 0) begin
               gap = 1 + ($unsigned($random(seed)) % 4); // 0..3 idle cycles
            end
            n = 0;
            while (n < gap) begin
               @(negedge pclk);
               start = 1'b0;
               req   = '0;
               if (!busy) begin
                  n++;
               end
            end
            start = 1'b1;
            req   = r;
         end
         @(negedge pclk);
         start = 1'b0;
         req   = '0;
         while (exp_q.size() > 0 || len_q.size() > 0 || remaining > 0) begin
            @(negedge pclk);
         end
         repeat (4) @(negedge pclk); // trailing idle beats
      end
      print_counts();
      if (beat_errors + flag_errors + other_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // start seen at edge t puts beat 0 out after edge t+1
   initial begin : monitor
      os_gen_pkg::os_beat_t exp_beat;
      logic                 exp_busy;
      logic                 exp_finish;
      @(posedge reset_n);
      forever begin
         @(posedge pclk);
         if (next_len > 0) begin
            remaining = next_len;
            next_len  = 0;
         end
         if (start) begin
            if (len_q.size() > 0) begin
               next_len = len_q.pop_front();
            end else begin
               other_errors++;
               $display("error: start seen with no expected set left");
            end
         end
         @(negedge pclk);
         if (remaining > 0) begin
            if (exp_q.size() > 0) begin
               exp_beat = exp_q.pop_front();
            end else begin
               exp_beat = '0;
               other_errors++;
               $display("error: a beat is due but no expected beat is left");
            end
            exp_finish = (remaining == 1);
            remaining--;
         end else begin
            exp_beat   = '0; // idle beat
            exp_finish = 1'b0;
         end
         exp_busy = (next_len > 0) ? (next_len > 1) : (remaining > 1);
         check_beat(beat, exp_beat);
         check_flags(busy, finish, exp_busy, exp_finish);
      end
   end

   initial begin : watchdog
      wait (loaded);
      #(limit_cycles * 8);
      other_errors++;
      $display("error: run timed out after %0d cycles", limit_cycles);
      print_counts();
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== os_vectors.txt ====
# R type link rate loopback lane_mode gap (hex) gap 0 = random 0..3 idle cycles, n = n-1 idle
# E data datak (hex) slot j of lane i is byte j*4+i, byte 0 rightmost
R 0 05 3 0 1 4
E 05050505bcbcbcbc 0f
E 0000000003020100 00
E 0000000008080808 00
E 4a4a4a4a4a4a4a4a 00
E 4a4a4a4a4a4a4a4a 00
E 4a4a4a4a4a4a4a4a 00
E 4a4a4a4a4a4a4a4a 00
E 4a4a4a4a4a4a4a4a 00
R 1 00 1 1 0 0
E f7f7f7f7bcbcbcbc ff
E 00000000f7f7f7f7 0f
E 0404040402020202 00
E 4545454545454545 00
E 4545454545454545 00
E 4545454545454545 00
E 4545454545454545 00
E 4545454545454545 00
R 0 1a 7 0 2 1
E 1a1a1a1abcbcbcbc 0f
E 0000000000010203 00
E 0000000020202020 00
E 4a4a4a4a4a4a4a4a 00
E 4a4a4a4a4a4a4a4a 00
E 4a4a4a4a4a4a4a4a 00
E 4a4a4a4a4a4a4a4a 00
E 4a4a4a4a4a4a4a4a 00
R 2 00 0 0 0 1
E 1c1c1c1cbcbcbcbc ff
E 1c1c1c1c1c1c1c1c ff
R 3 00 0 0 0 0
E 7c7c7c7cbcbcbcbc ff
E 7c7c7c7c7c7c7c7c ff
R 1 33 4 0 3 3
E 33333333bcbcbcbc 0f
E 0000000000010203 00
E 0000000010101010 00
E 4545454545454545 00
E 4545454545454545 00
E 4545454545454545 00
E 4545454545454545 00
E 4545454545454545 00
R 2 00 0 0 0 1
E 1c1c1c1cbcbcbcbc ff
E 1c1c1c1c1c1c1c1c ff

// ==== compile.f ====
os_gen_pkg.sv
os_field_builder.sv
os_symbol_sequencer.sv
os_lane_packer.sv
os_generator.sv
tb_os_generator.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_os_generator
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
